// ==== filelist.f ====
rtl/adma_pkg.sv
rtl/adma_desc_decode.sv
rtl/adma_sequencer.sv
rtl/axi_read_burst.sv
rtl/card_block_pacer.sv
rtl/adma_top.sv
verif/adma_props.sv
verif/adma_tb.sv

// ==== run.sh ====
#!/usr/bin/env bash
# build and run the ADMA testbench with Verilator
set -eo pipefail
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
  -f filelist.f --top-module adma_tb \
  --Mdir obj_dir -o adma_sim

./obj_dir/adma_sim | tee sim.log

if grep -q "TESTBENCH PASSED" sim.log; then
  echo "simulation passed"
else
  echo "simulation failed"
  exit 1
fi

// ==== verif/adma_tb.sv ====
`timescale 1ns/1ps

module adma_tb;
  import adma_pkg::*;

  localparam int unsigned burst_beats = 16;
  localparam int unsigned block_words = 128;

  // card data lives above the descriptor tables
  localparam addr_t data_base = 32'h0010_0000;

  logic       clock;
  logic       reset;
  logic       dma_enable;
  logic       cmd_compl_pulse;
  logic       data_present;
  addr_t      descriptor_pointer;
  logic       dat_int_rst;
  logic       xfer_compl;
  logic       ser_next_blk;
  axi_ar_t    ar;
  logic       arvalid;
  logic       arready;
  logic       rvalid;
  word_t      rdata;
  logic [1:0] rresp;
  logic       rlast;
  logic       rready;
  logic       fifo_write;
  word_t      fifo_data;
  logic       start_write;
  logic [1:0] dma_interrupts;

  // sparse system memory, descriptors only
  word_t       mem [addr_t];
  word_t       exp_words [$];
  logic [1:0]  exp_irq;
  addr_t       err_addr;
  int unsigned chain_words;
  int unsigned block_count;
  int unsigned errors;
  int unsigned words_checked;
  int unsigned cycle_count;
  int unsigned cycle_limit;

  adma_top #(.burst_beats(burst_beats), .block_words(block_words)) dut_i (
    .clock, .reset, .dma_enable, .cmd_compl_pulse, .data_present, .descriptor_pointer,
    .dat_int_rst, .xfer_compl, .ser_next_blk, .ar, .arvalid, .arready, .rvalid, .rdata,
    .rresp, .rlast, .rready, .fifo_write, .fifo_data, .start_write, .dma_interrupts
  );

  initial begin
    clock = 1'b0;
    forever #4 clock = ~clock;
  end

  //////////////////////////////////////////////////
  // memory and descriptor helpers
  //////////////////////////////////////////////////

  function automatic word_t mem_read(input addr_t a);
    if (mem.exists(a)) begin
      return mem[a];
    end
    // fill pattern, every address bit counts
    return {a[15:0], a[31:16]} ^ (a << 3) ^ 32'h6b3e_91d4;
  endfunction

  function automatic void put_desc(input addr_t at, input addr_t target,
                                   input int unsigned len_bytes, input attr_act_t act,
                                   input logic last, input logic valid);
    mem[at]     = {len_bytes[15:0], 10'd0, act, 2'b00, last, valid};
    mem[at + 4] = target;
  endfunction

  function automatic int unsigned rand_len();
    return 512 * $urandom_range(4, 1);
  endfunction

  function automatic addr_t data_addr(input int unsigned region);
    return data_base + (addr_t'(region) << 17) + (addr_t'($urandom_range(31, 0)) << 6);
  endfunction

  // tran only, last one carries End; zero_idx gets the 64 KiB length
  function automatic void build_tran_chain(input addr_t base, input int unsigned count,
                                           input int unsigned zero_idx,
                                           input int unsigned region);
    int unsigned i;
    int unsigned len_bytes;
    for (i = 0; i < count; i++) begin
      len_bytes = (i == zero_idx) ? 65536 : rand_len();
      put_desc(base + addr_t'(desc_bytes * i), data_addr(region + i), len_bytes,
               act_tran, i == count - 1, 1'b1);
    end
  endfunction

  // reference walk of the ADMA2 rules
  function automatic void walk_chain(input addr_t start);
    addr_t       ptr;
    addr_t       a;
    word_t       low;
    word_t       high;
    int unsigned n;
    int unsigned i;
    int unsigned step;
    logic        done;
    logic        hit;
    ptr  = start;
    done = 1'b0;
    for (step = 0; step < 64 && !done; step++) begin
      low  = mem_read(ptr);
      high = mem_read(ptr + 4);
      if (low[31:16] == 16'd0) begin
        n = 16384;
      end else begin
        n = low[31:18];
      end
      if (!low[0]) begin
        exp_irq = 2'b10;
        done    = 1'b1;
      end else if (low[5:4] == act_tran) begin
        hit = 1'b0;
        for (i = 0; i < n; i++) begin
          a = high + addr_t'(4 * i);
          exp_words.push_back(mem_read(a));
          if (a == err_addr) begin
            hit = 1'b1;
          end
        end
        chain_words += n;
        if (hit) begin
          exp_irq = 2'b10;
          done    = 1'b1;
        end else if (low[1]) begin
          exp_irq = 2'b01;
          done    = 1'b1;
        end else begin
          ptr += desc_bytes;
        end
      end else if (low[1]) begin
        exp_irq = 2'b01;
        done    = 1'b1;
      end else if (low[5:4] == act_link) begin
        ptr = high;
      end else begin
        ptr += desc_bytes;
      end
    end
  endfunction

  //////////////////////////////////////////////////
  // checks
  //////////////////////////////////////////////////

  task automatic check_word(input word_t got, input word_t exp);
    if (got !== exp) begin
      $display("[FAIL] %0t fifo_data 0x%08h, expected 0x%08h", $time, got, exp);
      errors++;
    end
  endtask

  task automatic check_irqs(input logic [1:0] got, input logic [1:0] exp);
    if (got !== exp) begin
      $display("[FAIL] %0t dma_interrupts %b, expected %b", $time, got, exp);
      errors++;
    end
  endtask

  task automatic check_burst_len(input logic [7:0] got, input logic [7:0] exp);
    if (got !== exp) begin
      $display("[FAIL] %0t ar.len %0d, expected %0d", $time, got, exp);
      errors++;
    end
  endtask

  task automatic clear_irqs();
    @(negedge clock);
    dat_int_rst = 1'b1;
    @(negedge clock);
    dat_int_rst = 1'b0;
    @(negedge clock);
    check_irqs(dma_interrupts, 2'b00);
  endtask

  task automatic expect_no_ar(input int unsigned cycles);
    repeat (cycles) begin
      @(negedge clock);
      if (arvalid) begin
        $display("arvalid raised after the engine stopped on a bad descriptor, at %0t", $time);
        errors++;
      end
    end
  endtask

  task automatic run_chain(input addr_t start);
    clear_irqs();
    exp_words.delete();
    chain_words = 0;
    block_count = 0;
    exp_irq     = 2'b00;
    walk_chain(start);
    cycle_limit += 20 * chain_words + 2000;
    @(negedge clock);
    descriptor_pointer = start;
    dma_enable         = 1'b1;
    data_present       = 1'b1;
    cmd_compl_pulse    = 1'b1;
    @(negedge clock);
    cmd_compl_pulse = 1'b0;
    while (exp_words.size() != 0) begin
      @(negedge clock);
    end
    // card side reports the end of the chain
    if (exp_irq == 2'b01) begin
      repeat (3) @(negedge clock);
      xfer_compl = 1'b1;
    end
    while (dma_interrupts == 2'b00) begin
      @(negedge clock);
    end
    xfer_compl = 1'b0;
    repeat (20) @(negedge clock);
    check_irqs(dma_interrupts, exp_irq);
    if (block_count != chain_words / block_words) begin
      $display("[FAIL] %0t %0d start_write pulses, expected %0d", $time, block_count,
               chain_words / block_words);
      errors++;
    end
  endtask

  //////////////////////////////////////////////////
  // bus and card models
  //////////////////////////////////////////////////

  initial begin : memory_model
    axi_ar_t    req;
    addr_t      beat_addr;
    logic [7:0] exp_len;
    int         i;
    wait (reset === 1'b1);
    forever begin
      @(negedge clock);
      if (arvalid) begin
        repeat ($urandom_range(3, 0)) @(negedge clock);
        req     = ar;
        arready = 1'b1;
        // descriptor lines are two beats, card data always fills whole bursts
        exp_len = (req.addr >= data_base) ? 8'(burst_beats - 1) : 8'(desc_bytes / 4 - 1);
        check_burst_len(req.len, exp_len);
        @(negedge clock);
        arready = 1'b0;
        for (i = 0; i <= int'(req.len); i++) begin
          while ($urandom_range(3, 0) == 0) begin
            @(negedge clock);
          end
          beat_addr = req.addr + addr_t'(4 * i);
          rvalid    = 1'b1;
          rdata     = mem_read(beat_addr);
          rresp     = (beat_addr == err_addr) ? 2'b10 : 2'b00;
          rlast     = (i == int'(req.len));
          if (rready !== 1'b1) begin
            $display("rready low while a read burst was open, at %0t", $time);
            errors++;
          end
          @(negedge clock);
          rvalid = 1'b0;
          rlast  = 1'b0;
          rresp  = 2'b00;
        end
      end
    end
  end

  // serializer asks for the next block after a short delay
  initial begin : card_model
    int unsigned delay;
    wait (reset === 1'b1);
    forever begin
      @(negedge clock);
      if (start_write) begin
        block_count++;
        delay = $urandom_range(5, 1);
        repeat (delay) begin
          @(negedge clock);
          if (fifo_write) begin
            $display("fifo write while the block was held, at %0t", $time);
            errors++;
          end
        end
        ser_next_blk = 1'b1;
        @(negedge clock);
        ser_next_blk = 1'b0;
      end
    end
  end

  always @(negedge clock) begin
    if (reset && fifo_write) begin
      if (exp_words.size() == 0) begin
        $display("fifo write with no word expected, at %0t", $time);
        errors++;
      end else begin
        check_word(fifo_data, exp_words.pop_front());
        words_checked++;
      end
    end
  end

  always @(posedge clock) begin
    cycle_count++;
    if (cycle_count > cycle_limit) begin
      $display("run timed out after %0d cycles", cycle_count);
      $display("TESTBENCH FAILED");
      $finish;
    end
  end

  //////////////////////////////////////////////////
  // test sequence
  //////////////////////////////////////////////////

  initial begin : main
    int unsigned count;
    word_t       err_low;
    addr_t       err_base;
    void'($urandom(32'h1c7a3dcc));
    reset              = 1'b0;
    dma_enable         = 1'b0;
    cmd_compl_pulse    = 1'b0;
    data_present       = 1'b0;
    descriptor_pointer = '0;
    dat_int_rst        = 1'b0;
    xfer_compl         = 1'b0;
    ser_next_blk       = 1'b0;
    arready            = 1'b0;
    rvalid             = 1'b0;
    rdata              = '0;
    rresp              = 2'b00;
    rlast              = 1'b0;
    errors             = 0;
    words_checked      = 0;
    cycle_count        = 0;
    cycle_limit        = 2000;
    err_addr           = 32'hffff_fffc;
    repeat (4) @(posedge clock);
    @(negedge clock);
    reset = 1'b1;

    // tran chain with one 64 KiB descriptor
    count = $urandom_range(5, 3);
    build_tran_chain(32'h0000_1000, count, $urandom_range(count - 1, 0), 0);
    run_chain(32'h0000_1000);

    // nop, reserved and link steps, ends on a nop
    put_desc(32'h0000_2000, data_addr(0), rand_len(), act_tran, 1'b0, 1'b1);
    put_desc(32'h0000_2008, '0, 0, act_nop, 1'b0, 1'b1);
    put_desc(32'h0000_2010, 32'h0000_2800, 0, act_link, 1'b0, 1'b1);
    put_desc(32'h0000_2018, '0, 0, act_tran, 1'b1, 1'b0);
    put_desc(32'h0000_2800, '0, 0, act_rsv, 1'b0, 1'b1);
    put_desc(32'h0000_2808, data_addr(1), rand_len(), act_tran, 1'b0, 1'b1);
    put_desc(32'h0000_2810, 32'h0000_2400, 0, act_link, 1'b0, 1'b1);
    put_desc(32'h0000_2400, data_addr(2), rand_len(), act_tran, 1'b0, 1'b1);
    put_desc(32'h0000_2408, '0, 0, act_nop, 1'b1, 1'b1);
    run_chain(32'h0000_2000);

    // invalid line after one transfer
    put_desc(32'h0000_3000, data_addr(3), rand_len(), act_tran, 1'b0, 1'b1);
    put_desc(32'h0000_3008, data_addr(4), 512, act_tran, 1'b1, 1'b0);
    run_chain(32'h0000_3000);
    expect_no_ar(40);

    // error response inside the second transfer
    build_tran_chain(32'h0000_4000, 3, 3, 5);
    err_low  = mem_read(32'h0000_4008);
    err_base = mem_read(32'h0000_400c);
    err_addr = err_base + (addr_t'($urandom_range({18'd0, err_low[31:18]} - 1, 0)) << 2);
    run_chain(32'h0000_4000);

    // clean restart after the error
    err_addr = 32'hffff_fffc;
    build_tran_chain(32'h0000_5000, 3, 3, 9);
    run_chain(32'h0000_5000);

    $display("errors %0d, words checked %0d", errors, words_checked);
    if (errors == 0) begin
      $display("TESTBENCH PASSED");
    end else begin
      $display("TESTBENCH FAILED");
    end
    $finish;
  end

endmodule

// ==== verif/adma_props.sv ====
`timescale 1ns/1ps

module adma_props (
  input logic              clock,
  input logic              reset,
  input adma_pkg::axi_ar_t ar,
  input logic              arvalid,
  input logic              arready,
  input logic              block_hold,
  input logic              job_start,
  input logic              start_write
);

  // address request held until accepted
  ar_stable: assert property (@(posedge clock) disable iff (!reset)
    arvalid && !arready |=> arvalid && $stable(ar))
    else $error("ar changed or arvalid dropped before arready");

  // open job waits for the serializer before its next burst
  hold_blocks_ar: assert property (@(posedge clock) disable iff (!reset)
    block_hold && !job_start |=> !$rose(arvalid))
    else $error("arvalid rose while block_hold was high");

  start_pulse: assert property (@(posedge clock) disable iff (!reset)
    start_write |=> !start_write)
    else $error("start_write longer than one cycle");

endmodule

bind axi_read_burst adma_props read_props_i (
  .clock, .reset, .ar, .arvalid, .arready, .block_hold, .job_start,
  .start_write(1'b0)
);

bind card_block_pacer adma_props pace_props_i (
  .clock, .reset, .ar('0), .arvalid(1'b0), .arready(1'b0), .block_hold,
  .job_start(1'b0), .start_write
);

// ==== rtl/adma_top.sv ====
`timescale 1ns/1ps

module adma_top #(
  parameter int unsigned burst_beats = 16,
  parameter int unsigned block_words = 128
) (
  input  logic              clock,
  input  logic              reset,
  input  logic              dma_enable,
  input  logic              cmd_compl_pulse,
  input  logic              data_present,
  input  adma_pkg::addr_t   descriptor_pointer,
  input  logic              dat_int_rst,
  input  logic              xfer_compl,
  input  logic              ser_next_blk,
  output adma_pkg::axi_ar_t ar,
  output logic              arvalid,
  input  logic              arready,
  input  logic              rvalid,
  input  adma_pkg::word_t   rdata,
  input  logic [1:0]        rresp,
  input  logic              rlast,
  output logic              rready,
  output logic              fifo_write,
  output adma_pkg::word_t   fifo_data,
  output logic              start_write,
  output logic [1:0]        dma_interrupts
);
  import adma_pkg::*;

  read_job_t  job;
  logic       job_start;
  logic       job_done;
  logic       resp_error;
  logic       beat_valid;
  word_t      beat_data;
  logic       desc_beat;
  logic       card_beat;
  adma_desc_t desc;
  logic       desc_ready;
  logic       block_hold;

  // returned beats follow the job target
  assign desc_beat = beat_valid && !job.to_card;
  assign card_beat = beat_valid && job.to_card;

  adma_sequencer sequencer_i (
    .clock, .reset, .dma_enable, .cmd_compl_pulse, .data_present, .descriptor_pointer,
    .dat_int_rst, .xfer_compl, .desc, .desc_ready, .job_done, .resp_error,
    .job, .job_start, .dma_interrupts
  );

  axi_read_burst #(.burst_beats(burst_beats)) reader_i (
    .clock, .reset, .job, .job_start, .block_hold, .ar, .arvalid, .arready,
    .rvalid, .rdata, .rresp, .rlast, .rready, .beat_valid, .beat_data,
    .job_done, .resp_error
  );

  adma_desc_decode decode_i (
    .clock, .reset, .beat_valid(desc_beat), .beat_data, .desc, .desc_ready
  );

  card_block_pacer #(.block_words(block_words)) pacer_i (
    .clock, .reset, .beat_valid(card_beat), .beat_data, .ser_next_blk, .xfer_compl,
    .fifo_write, .fifo_data, .start_write, .block_hold
  );

endmodule

// ==== rtl/card_block_pacer.sv ====
`timescale 1ns/1ps

module card_block_pacer #(
  parameter int unsigned block_words = 128
) (
  input  logic            clock,
  input  logic            reset,
  input  logic            beat_valid,
  input  adma_pkg::word_t beat_data,
  input  logic            ser_next_blk,
  input  logic            xfer_compl,
  output logic            fifo_write,
  output adma_pkg::word_t fifo_data,
  output logic            start_write,
  output logic            block_hold
);

  localparam int unsigned cnt_w = $clog2(block_words);

  logic [cnt_w-1:0] word_cnt;
  logic             block_end;

  // last word of the current block
  assign block_end = beat_valid && (word_cnt == cnt_w'(block_words - 1));

  //////////////////////////////////////////////////
  // block counting and hold
  //////////////////////////////////////////////////

  always_ff @(posedge clock) begin
    if (!reset) begin
      fifo_write  <= 1'b0;
      start_write <= 1'b0;
      block_hold  <= 1'b0;
      word_cnt    <= '0;
    end else begin
      fifo_write  <= beat_valid;
      start_write <= block_end;
      if (beat_valid) begin
        word_cnt <= block_end ? '0 : word_cnt + 1'b1;
      end
      // serializer wants the next block
      if (ser_next_blk || xfer_compl) begin
        block_hold <= 1'b0;
      end
      if (block_end) begin
        block_hold <= 1'b1;
      end
    end
  end

  always_ff @(posedge clock) begin
    if (beat_valid) begin
      fifo_data <= beat_data;
    end
  end

endmodule

// ==== rtl/axi_read_burst.sv ====
`timescale 1ns/1ps

module axi_read_burst #(
  parameter int unsigned burst_beats = 16
) (
  input  logic                clock,
  input  logic                reset,
  input  adma_pkg::read_job_t job,
  input  logic                job_start,
  input  logic                block_hold,
  output adma_pkg::axi_ar_t   ar,
  output logic                arvalid,
  input  logic                arready,
  input  logic                rvalid,
  input  adma_pkg::word_t     rdata,
  input  logic [1:0]          rresp,
  input  logic                rlast,
  output logic                rready,
  output logic                beat_valid,
  output adma_pkg::word_t     beat_data,
  output logic                job_done,
  output logic                resp_error
);
  import adma_pkg::*;

  typedef enum logic [1:0] {
    rd_idle,
    rd_addr,
    rd_data,
    rd_next  // between bursts, honours block_hold
  } rd_state_t;

  rd_state_t   state;
  addr_t       next_addr;
  word_count_t words_left;
  addr_t       src_addr;
  word_count_t src_words;
  word_count_t burst_words;
  logic        issue;

  // new job or the rest of the current one
  assign src_addr  = (state == rd_idle) ? job.addr : next_addr;
  assign src_words = (state == rd_idle) ? job.words : words_left;

  assign burst_words = (src_words > word_count_t'(burst_beats)) ?
                       word_count_t'(burst_beats) : src_words;

  assign issue = ((state == rd_idle) && job_start && (job.words != '0)) ||
                 ((state == rd_next) && !block_hold);

  assign beat_valid = rvalid && rready;
  assign beat_data  = rdata;
  assign resp_error = beat_valid && rresp[1];

  always_ff @(posedge clock) begin
    if (!reset) begin
      state    <= rd_idle;
      arvalid  <= 1'b0;
      rready   <= 1'b0;
      job_done <= 1'b0;
    end else begin
      job_done <= 1'b0;
      if (issue) begin
        ar.addr    <= src_addr;
        ar.len     <= 8'(burst_words - 1'b1);
        next_addr  <= src_addr + (addr_t'(burst_words) << 2);
        words_left <= src_words - burst_words;
        arvalid    <= 1'b1;
        state      <= rd_addr;
      end else begin
        case (state)
          rd_idle: begin
            // empty job, nothing to read
            if (job_start) begin
              job_done <= 1'b1;
            end
          end
          rd_addr: begin
            if (arready) begin
              arvalid <= 1'b0;
              rready  <= 1'b1;
              state   <= rd_data;
            end
          end
          rd_data: begin
            if (beat_valid && rlast) begin
              rready <= 1'b0;
              if (words_left == '0) begin
                job_done <= 1'b1;
                state    <= rd_idle;
              end else begin
                state <= rd_next;
              end
            end
          end
          default: begin
            // held off by the pacer
            state <= rd_next;
          end
        endcase
      end
    end
  end

endmodule

// ==== rtl/adma_sequencer.sv ====
`timescale 1ns/1ps

module adma_sequencer (
  input  logic                 clock,
  input  logic                 reset,
  input  logic                 dma_enable,
  input  logic                 cmd_compl_pulse,
  input  logic                 data_present,
  input  adma_pkg::addr_t      descriptor_pointer,
  input  logic                 dat_int_rst,
  input  logic                 xfer_compl,
  input  adma_pkg::adma_desc_t desc,
  input  logic                 desc_ready,
  input  logic                 job_done,
  input  logic                 resp_error,
  output adma_pkg::read_job_t  job,
  output logic                 job_start,
  output logic [1:0]           dma_interrupts
);
  import adma_pkg::*;

  localparam word_count_t fetch_words = word_count_t'(desc_bytes / 4);

  typedef enum logic [1:0] {
    st_stop,
    st_fds,   // fetch descriptor
    st_cadr,  // change address
    st_tfr    // transfer data
  } adma_state_t;

  adma_state_t state;
  addr_t       desc_ptr;
  addr_t       next_ptr;
  logic        start_req;
  logic        abort_pending;
  logic        xfer_wait;

  assign start_req = dma_enable && cmd_compl_pulse && data_present;

  // link jumps, everything else walks to the next line
  assign next_ptr = (desc.act == act_link) ? desc.addr : desc_ptr + addr_t'(desc_bytes);

  //////////////////////////////////////////////////
  // ADMA2 state machine
  //////////////////////////////////////////////////

  always_ff @(posedge clock) begin
    if (!reset) begin
      state          <= st_stop;
      job_start      <= 1'b0;
      dma_interrupts <= 2'b00;
      abort_pending  <= 1'b0;
      xfer_wait      <= 1'b0;
    end else begin
      job_start <= 1'b0;

      // bad read response, let the burst drain first
      if (resp_error) begin
        dma_interrupts[1] <= 1'b1;
        abort_pending     <= 1'b1;
      end

      if (job_done && abort_pending) begin
        state         <= st_stop;
        abort_pending <= 1'b0;
        xfer_wait     <= 1'b0;
      end else begin
        case (state)
          st_stop: begin
            if (start_req) begin
              desc_ptr  <= descriptor_pointer;
              job       <= '{addr: descriptor_pointer, words: fetch_words, to_card: 1'b0};
              job_start <= 1'b1;
              state     <= st_fds;
            end
          end

          st_fds: begin
            if (desc_ready) begin
              state <= st_cadr;
            end
          end

          st_cadr: begin
            if (!desc.valid) begin
              dma_interrupts[1] <= 1'b1;
              state             <= st_stop;
            end else if (desc.act == act_tran) begin
              desc_ptr  <= next_ptr;
              job       <= '{addr: desc.addr, words: desc.words, to_card: 1'b1};
              job_start <= 1'b1;
              state     <= st_tfr;
            end else if (!desc.last) begin
              // nop, reserved or link, fetch again
              desc_ptr  <= next_ptr;
              job       <= '{addr: next_ptr, words: fetch_words, to_card: 1'b0};
              job_start <= 1'b1;
              state     <= st_fds;
            end else if (xfer_compl) begin
              dma_interrupts[0] <= 1'b1;
              state             <= st_stop;
            end
          end

          st_tfr: begin
            if (job_done) begin
              if (desc.last) begin
                xfer_wait <= 1'b1;
              end else begin
                job       <= '{addr: desc_ptr, words: fetch_words, to_card: 1'b0};
                job_start <= 1'b1;
                state     <= st_fds;
              end
            end
            // end of chain, card side must finish too
            if (xfer_wait && xfer_compl) begin
              dma_interrupts[0] <= 1'b1;
              xfer_wait         <= 1'b0;
              state             <= st_stop;
            end
          end

          default: begin
            state <= st_stop;
          end
        endcase
      end

      if (dat_int_rst) begin
        dma_interrupts <= 2'b00;
      end
    end
  end

endmodule

// ==== rtl/adma_desc_decode.sv ====
`timescale 1ns/1ps

module adma_desc_decode (
  input  logic                 clock,
  input  logic                 reset,
  input  logic                 beat_valid,
  input  adma_pkg::word_t      beat_data,
  output adma_pkg::adma_desc_t desc,
  output logic                 desc_ready
);
  import adma_pkg::*;

  // length 0 stands for 65536 bytes
  localparam word_count_t max_words = 15'd16384;

  word_t       low_word;
  logic        low_seen;
  logic [15:0] length;

  assign length = low_word[31:16];

  // word toggle and ready strobe
  always_ff @(posedge clock) begin
    if (!reset) begin
      low_seen   <= 1'b0;
      desc_ready <= 1'b0;
    end else begin
      desc_ready <= 1'b0;
      if (beat_valid) begin
        low_seen   <= !low_seen;
        desc_ready <= low_seen;
      end
    end
  end

  // first beat is attributes and length, second is the address
  always_ff @(posedge clock) begin
    if (beat_valid && !low_seen) begin
      low_word <= beat_data;
    end
    if (beat_valid && low_seen) begin
      desc.addr  <= beat_data;
      desc.act   <= attr_act_t'(low_word[5:4]);
      desc.last  <= low_word[1];
      desc.valid <= low_word[0];
      if (length == 16'd0) begin
        desc.words <= max_words;
      end else begin
        desc.words <= word_count_t'(length[15:2]);
      end
    end
  end

endmodule

// ==== rtl/adma_pkg.sv ====
package adma_pkg;

  //////////////////////////////////////////////////
  // basic widths
  //////////////////////////////////////////////////

  // system memory byte address
  typedef logic [31:0] addr_t;

  // one 32-bit beat on the read data channel
  typedef logic [31:0] word_t;

  // up to 16384 words, the 64 KiB zero-length case
  typedef logic [14:0] word_count_t;

  // one descriptor line is two words
  localparam int unsigned desc_bytes = 8;

  //////////////////////////////////////////////////
  // descriptor line
  //////////////////////////////////////////////////

  // action field, low word bits 5:4
  typedef enum logic [1:0] {
    act_nop  = 2'd0,
    act_rsv  = 2'd1,  // reserved, behaves as nop
    act_tran = 2'd2,
    act_link = 2'd3
  } attr_act_t;

  typedef struct packed {
    addr_t       addr;
    word_count_t words;
    attr_act_t   act;
    logic        last;   // End attribute
    logic        valid;
  } adma_desc_t;

  //////////////////////////////////////////////////
  // read path
  //////////////////////////////////////////////////

  // to_card low sends beats to the decoder
  typedef struct packed {
    addr_t       addr;
    word_count_t words;
    logic        to_card;
  } read_job_t;

  // INCR bursts of 4-byte beats only
  typedef struct packed {
    addr_t      addr;
    logic [7:0] len;  // beats minus one
  } axi_ar_t;

endpackage
